// File: design/host_bus_pkg.sv
// ####################################################################
// Host port types. Single-cycle strobes, no back-pressure; a target
// result is only meaningful in the cycle the crossbar expects it.
// ####################################################################

package host_bus_pkg;

  typedef enum logic {
    BUS_READ  = 1'b0,
    BUS_WRITE = 1'b1
  } bus_op_e;

  // Request from the host, valid for exactly one cycle
  typedef struct packed {
    logic        valid;
    bus_op_e     op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
  } bus_req_t;

  // Response toward the host
  typedef struct packed {
    logic        valid;
    logic        err;
    logic [31:0] rdata;
  } bus_rsp_t;

  // Target result, timing is implied by the crossbar
  typedef struct packed {
    logic        err;
    logic [31:0] rdata;
  } slv_rsp_t;

endpackage

// File: design/host_domain.sv
// ####################################################################
// Host domain top, single clock. Fixed one-cycle response latency,
// one request per cycle, unmapped addresses answer with an error.
// ####################################################################

`include "host_cfg.svh"

module host_domain (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  host_bus_pkg::bus_req_t       req_i,
  output host_bus_pkg::bus_rsp_t       rsp_o,
  input  logic [`HOST_NUM_GPIO-1:0]    gpio_i,
  output host_periph_pkg::gpio_pads_t  gpio_o,
  input  logic                         event_i
);

  host_bus_pkg::bus_req_t mem_req;
  host_bus_pkg::bus_req_t per_req;
  host_bus_pkg::slv_rsp_t mem_rsp;
  host_bus_pkg::slv_rsp_t per_rsp;

  host_xbar i_xbar (
    .clk_i     ( clk_i   ),
    .rst_n_i   ( rst_n_i ),
    .req_i     ( req_i   ),
    .rsp_o     ( rsp_o   ),
    .mem_req_o ( mem_req ),
    .mem_rsp_i ( mem_rsp ),
    .per_req_o ( per_req ),
    .per_rsp_i ( per_rsp )
  );

  l2_bank_mem i_l2 (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .req_i   ( mem_req ),
    .rsp_o   ( mem_rsp )
  );

  periph_regs i_periph (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .req_i   ( per_req ),
    .rsp_o   ( per_rsp ),
    .gpio_i  ( gpio_i  ),
    .gpio_o  ( gpio_o  ),
    .event_i ( event_i )
  );

endmodule

// File: design/host_periph_pkg.sv
// ####################################################################
// Peripheral register map and GPIO pad bundle. Slots not listed in
// the enum answer with an error.
// ####################################################################

`include "host_cfg.svh"

package host_periph_pkg;

  // Word index inside the peripheral region
  typedef enum logic [$clog2(`HOST_PERIPH_WORDS)-1:0] {
    REG_GPIO_OUT  = 'd0,
    REG_GPIO_DIR  = 'd1,
    REG_GPIO_IN   = 'd2,
    REG_EVENT_CNT = 'd3,
    REG_SCRATCH   = 'd4,
    REG_ID        = 'd5
  } periph_reg_e;

  // Pad side, dir bit high drives the pad
  typedef struct packed {
    logic [`HOST_NUM_GPIO-1:0] gpio_out;
    logic [`HOST_NUM_GPIO-1:0] gpio_dir;
  } gpio_pads_t;

endpackage

// File: design/host_xbar.sv
// ####################################################################
// Host crossbar, one request per cycle and no back-pressure. Both
// targets must answer exactly one cycle after their request.
// ####################################################################

`include "host_cfg.svh"

module host_xbar (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  host_bus_pkg::bus_req_t req_i,
  output host_bus_pkg::bus_rsp_t rsp_o,
  output host_bus_pkg::bus_req_t mem_req_o,
  input  host_bus_pkg::slv_rsp_t mem_rsp_i,
  output host_bus_pkg::bus_req_t per_req_o,
  input  host_bus_pkg::slv_rsp_t per_rsp_i
);

  localparam logic [31:0] MemBase = `HOST_L2_BASE;
  localparam logic [31:0] MemSize = 32'(`HOST_L2_BANKS * `HOST_L2_BANK_WORDS * 4);
  localparam logic [31:0] PerBase = `HOST_PERIPH_BASE;
  localparam logic [31:0] PerSize = 32'(`HOST_PERIPH_WORDS * 4);

  // Which target owes a response in the current cycle
  typedef enum logic [1:0] {
    TGT_NONE,
    TGT_MEM,
    TGT_PER,
    TGT_MISS
  } tgt_e;

  tgt_e tgt_d;
  tgt_e tgt_q;
  logic mem_hit;
  logic per_hit;

  assign mem_hit = (req_i.addr >= MemBase) && (req_i.addr < MemBase + MemSize);
  assign per_hit = (req_i.addr >= PerBase) && (req_i.addr < PerBase + PerSize);

  always_comb begin
    mem_req_o       = req_i;
    mem_req_o.valid = req_i.valid && mem_hit;
    per_req_o       = req_i;
    per_req_o.valid = req_i.valid && per_hit;
    if (!req_i.valid) tgt_d = TGT_NONE;
    else if (mem_hit) tgt_d = TGT_MEM;
    else if (per_hit) tgt_d = TGT_PER;
    else              tgt_d = TGT_MISS;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tgt_q <= TGT_NONE;
    end else begin
      tgt_q <= tgt_d;
    end
  end

  // Response is steered from the target results, no extra register
  always_comb begin
    rsp_o.valid = (tgt_q != TGT_NONE);
    rsp_o.err   = 1'b0;
    rsp_o.rdata = '0;
    case (tgt_q)
      TGT_MEM:  {rsp_o.err, rsp_o.rdata} = mem_rsp_i;
      TGT_PER:  {rsp_o.err, rsp_o.rdata} = per_rsp_i;
      TGT_MISS: rsp_o.err = 1'b1;
      default:  rsp_o.err = 1'b0;
    endcase
  end

endmodule

// File: design/l2_bank_mem.sv
// ####################################################################
// Word-interleaved L2 scratchpad. Address bits above the region size
// are ignored, so the crossbar must only pass in-range requests.
// ####################################################################

`include "host_cfg.svh"

module l2_bank_mem (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  host_bus_pkg::bus_req_t req_i,
  output host_bus_pkg::slv_rsp_t rsp_o
);

  localparam int Banks    = `HOST_L2_BANKS;
  localparam int Rows     = `HOST_L2_BANK_WORDS;
  localparam int BankBits = $clog2(Banks);
  localparam int RowBits  = $clog2(Rows);

  logic [BankBits-1:0] bank_sel;
  logic [RowBits-1:0]  row_sel;
  logic                wr_en;
  logic                rd_en;
  logic [Banks-1:0]    bank_we;
  logic [31:0]         bank_rdata [Banks];
  logic [31:0]         rdata_q;

  // Low word bits pick the bank, the next bits the row
  assign bank_sel = req_i.addr[2 +: BankBits];
  assign row_sel  = req_i.addr[2 + BankBits +: RowBits];

  assign wr_en = req_i.valid && (req_i.op == host_bus_pkg::BUS_WRITE);
  assign rd_en = req_i.valid && (req_i.op == host_bus_pkg::BUS_READ);

  for (genvar b = 0; b < Banks; b++) begin : g_bank
    logic [31:0] mem_q [Rows];

    assign bank_we[b] = wr_en && (bank_sel == BankBits'(b));

    always_ff @(posedge clk_i) begin
      if (bank_we[b]) begin
        for (int i = 0; i < 4; i++) begin
          if (req_i.strb[i]) begin
            mem_q[row_sel][8*i +: 8] <= req_i.wdata[8*i +: 8];
          end
        end
      end
    end

    assign bank_rdata[b] = mem_q[row_sel];
  end

  // Read data lands one cycle after the request, writes return zero
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (rd_en) begin
      rdata_q <= bank_rdata[bank_sel];
    end else if (wr_en) begin
      rdata_q <= '0;
    end
  end

  assign rsp_o.err   = 1'b0;
  assign rsp_o.rdata = rdata_q;

endmodule

// File: design/periph_regs.sv
// ####################################################################
// GPIO, event counter, scratch and ID registers. GPIO writes ignore
// the byte strobes; gpio_i is resynchronised, so reads lag two cycles.
// ####################################################################

`include "host_cfg.svh"

module periph_regs (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  host_bus_pkg::bus_req_t       req_i,
  output host_bus_pkg::slv_rsp_t       rsp_o,
  input  logic [`HOST_NUM_GPIO-1:0]    gpio_i,
  output host_periph_pkg::gpio_pads_t  gpio_o,
  input  logic                         event_i
);

  localparam int IdxBits = $clog2(`HOST_PERIPH_WORDS);

  host_periph_pkg::periph_reg_e reg_idx;
  host_periph_pkg::gpio_pads_t  gpio_q;
  host_bus_pkg::slv_rsp_t       rsp_q;
  logic [`HOST_NUM_GPIO-1:0]    gpio_meta_q;
  logic [`HOST_NUM_GPIO-1:0]    gpio_sync_q;
  logic [31:0]                  event_cnt_q;
  logic [31:0]                  scratch_q;
  logic [31:0]                  rd_val;
  logic                         is_write;
  logic                         acc_err;
  logic                         wr_ok;

  assign reg_idx  = host_periph_pkg::periph_reg_e'(req_i.addr[2 +: IdxBits]);
  assign is_write = (req_i.op == host_bus_pkg::BUS_WRITE);

  always_comb begin
    rd_val  = '0;
    acc_err = 1'b0;
    case (reg_idx)
      host_periph_pkg::REG_GPIO_OUT:  rd_val = 32'(gpio_q.gpio_out);
      host_periph_pkg::REG_GPIO_DIR:  rd_val = 32'(gpio_q.gpio_dir);
      host_periph_pkg::REG_EVENT_CNT: rd_val = event_cnt_q;
      host_periph_pkg::REG_SCRATCH:   rd_val = scratch_q;
      host_periph_pkg::REG_GPIO_IN: begin
        rd_val  = 32'(gpio_sync_q);
        acc_err = is_write;
      end
      host_periph_pkg::REG_ID: begin
        rd_val  = `HOST_PERIPH_ID;
        acc_err = is_write;
      end
      default: acc_err = 1'b1;
    endcase
  end

  // Rejected writes leave every register untouched
  assign wr_ok = req_i.valid && is_write && !acc_err;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_q      <= '0;
      gpio_meta_q <= '0;
      gpio_sync_q <= '0;
      event_cnt_q <= '0;
      scratch_q   <= '0;
      rsp_q       <= '0;
    end else begin
      gpio_meta_q <= gpio_i;
      gpio_sync_q <= gpio_meta_q;
      // A write of any value clears the count and wins over an event
      if (wr_ok && reg_idx == host_periph_pkg::REG_EVENT_CNT) begin
        event_cnt_q <= '0;
      end else if (event_i) begin
        event_cnt_q <= event_cnt_q + 32'd1;
      end
      if (wr_ok && reg_idx == host_periph_pkg::REG_GPIO_OUT) begin
        gpio_q.gpio_out <= req_i.wdata[`HOST_NUM_GPIO-1:0];
      end
      if (wr_ok && reg_idx == host_periph_pkg::REG_GPIO_DIR) begin
        gpio_q.gpio_dir <= req_i.wdata[`HOST_NUM_GPIO-1:0];
      end
      if (wr_ok && reg_idx == host_periph_pkg::REG_SCRATCH) begin
        for (int i = 0; i < 4; i++) begin
          if (req_i.strb[i]) scratch_q[8*i +: 8] <= req_i.wdata[8*i +: 8];
        end
      end
      if (req_i.valid) begin
        rsp_q.err   <= acc_err;
        rsp_q.rdata <= (acc_err || is_write) ? '0 : rd_val;
      end
    end
  end

  assign rsp_o  = rsp_q;
  assign gpio_o = gpio_q;

endmodule

// File: include/host_cfg.svh
// ####################################################################
// Build-time sizing for the host domain. Bank count must be a power
// of two, and both regions must sit on boundaries of their own size.
// ####################################################################

`ifndef HOST_CFG_SVH
`define HOST_CFG_SVH

// L2 scratchpad geometry, 32-bit words
`define HOST_L2_BANKS      4
`define HOST_L2_BANK_WORDS 64

// GPIO pads
`define HOST_NUM_GPIO 16

// Address map, byte addresses
`define HOST_L2_BASE     32'h1C00_0000
`define HOST_PERIPH_BASE 32'h1A10_0000
`define HOST_PERIPH_WORDS 16

// Value of the read-only ID register
`define HOST_PERIPH_ID 32'hC0DE_0A51

`endif

// File: list.f
+incdir+include
design/host_bus_pkg.sv
design/host_periph_pkg.sv
design/l2_bank_mem.sv
design/periph_regs.sv
design/host_xbar.sv
design/host_domain.sv
verif/tb_host_domain.sv

// File: run_sim.sh
#!/bin/sh
# Build the host domain testbench with Verilator and run it.
# The run counts as passed only if the pass line shows up in the output.
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps \
  --top-module tb_host_domain -Mdir obj_dir -f list.f &&
./obj_dir/Vtb_host_domain | tee /dev/stderr | grep -qx "sim passed" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }

// File: verif/tb_host_domain.sv
// ####################################################################
// Table-driven testbench for host_domain. Expects a fixed one-cycle
// response; L2 words are always fully written before they are read.
// ####################################################################

`include "host_cfg.svh"

module tb_host_domain;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          L2Words    = `HOST_L2_BANKS * `HOST_L2_BANK_WORDS;
  localparam logic [31:0] L2Base     = `HOST_L2_BASE;
  localparam logic [31:0] PerBase    = `HOST_PERIPH_BASE;
  localparam int          RspTimeout = 10;

  // One stimulus row, the name lives in a queue alongside
  typedef struct packed {
    host_bus_pkg::bus_op_e op;
    logic [31:0]           addr;
    logic [31:0]           wdata;
    logic [3:0]            strb;
    logic [31:0]           exp_rdata;
    logic                  use_model;
    logic                  exp_err;
  } row_t;

  logic                        clk = 1'b0;
  logic                        rst_n;
  host_bus_pkg::bus_req_t      req;
  host_bus_pkg::bus_rsp_t      rsp;
  logic [`HOST_NUM_GPIO-1:0]   gpio_in;
  host_periph_pkg::gpio_pads_t gpio_pads;
  logic                        event_in;

  row_t        rows [$];
  string       names [$];
  logic [31:0] l2_model [L2Words];
  int          err_cnt;
  int          tmo_cnt;
  integer      seed;

  host_domain i_dut (
    .clk_i   ( clk       ),
    .rst_n_i ( rst_n     ),
    .req_i   ( req       ),
    .rsp_o   ( rsp       ),
    .gpio_i  ( gpio_in   ),
    .gpio_o  ( gpio_pads ),
    .event_i ( event_in  )
  );

  initial begin
    forever #10 clk = ~clk;
  end

  function automatic int word_idx(input logic [31:0] addr);
    return int'((addr - L2Base) >> 2);
  endfunction

  function automatic logic is_l2(input logic [31:0] addr);
    return (addr >= L2Base) && (addr < L2Base + 32'(L2Words * 4));
  endfunction

  function automatic logic [31:0] reg_addr(input logic [3:0] idx);
    return PerBase + {26'b0, idx, 2'b00};
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp,
                           input logic [31:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  // Byte merge, mirrors the strobe rule of the scratchpad
  task automatic model_write(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] strb);
    int w;
    w = word_idx(addr);
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) l2_model[w][8*i +: 8] = wdata[8*i +: 8];
    end
  endtask

  task automatic write_row(input string name, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] strb,
                           input logic exp_err);
    row_t r;
    r.op        = host_bus_pkg::BUS_WRITE;
    r.addr      = addr;
    r.wdata     = wdata;
    r.strb      = strb;
    r.exp_rdata = '0;
    r.use_model = 1'b0;
    r.exp_err   = exp_err;
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic read_row(input string name, input logic [31:0] addr,
                          input logic [31:0] exp_rdata, input logic use_model,
                          input logic exp_err);
    row_t r;
    r.op        = host_bus_pkg::BUS_READ;
    r.addr      = addr;
    r.wdata     = '0;
    r.strb      = 4'hf;
    r.exp_rdata = exp_rdata;
    r.use_model = use_model;
    r.exp_err   = exp_err;
    rows.push_back(r);
    names.push_back(name);
  endtask

  // Rows go out back to back, each checked one falling edge later
  task automatic apply_rows();
    logic [31:0] exp;
    int          lat;
    for (int i = 0; i < rows.size(); i++) begin
      req.valid = 1'b1;
      req.op    = rows[i].op;
      req.addr  = rows[i].addr;
      req.wdata = rows[i].wdata;
      req.strb  = rows[i].strb;
      if (rows[i].op == host_bus_pkg::BUS_WRITE && is_l2(rows[i].addr)) begin
        model_write(rows[i].addr, rows[i].wdata, rows[i].strb);
      end
      @(negedge clk);
      lat = 1;
      while (!rsp.valid && lat < RspTimeout) begin
        req.valid = 1'b0;
        @(negedge clk);
        lat++;
      end
      if (!rsp.valid) begin
        $display("Timeout: no response to %s after %0d cycles", names[i], lat);
        tmo_cnt++;
      end else begin
        exp = rows[i].use_model ? l2_model[word_idx(rows[i].addr)] : rows[i].exp_rdata;
        check_val({names[i], " latency"}, 32'd1, 32'(lat));
        check_val({names[i], " err"}, 32'(rows[i].exp_err), 32'(rsp.err));
        check_val({names[i], " rdata"}, exp, rsp.rdata);
      end
    end
    req.valid = 1'b0;
    rows.delete();
    names.delete();
  endtask

  initial begin
    err_cnt  = 0;
    tmo_cnt  = 0;
    seed     = 32'h4baa;
    rst_n    = 1'b0;
    req      = '0;
    gpio_in  = '0;
    event_in = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    check_val("reset rsp valid", 32'd0, 32'(rsp.valid));
    check_val("reset gpio out", 32'd0, 32'(gpio_pads.gpio_out));
    check_val("reset gpio dir", 32'd0, 32'(gpio_pads.gpio_dir));

    // Words 0 and 4 share bank 0, words 0 and 1 sit in neighbour banks
    write_row("l2 w0 full", L2Base + 32'd0, $random(seed), 4'hf, 1'b0);
    write_row("l2 w1 full", L2Base + 32'd4, $random(seed), 4'hf, 1'b0);
    write_row("l2 w4 full", L2Base + 32'd16, $random(seed), 4'hf, 1'b0);
    write_row("l2 w255 full", L2Base + 32'd1020, $random(seed), 4'hf, 1'b0);
    write_row("l2 w0 part", L2Base + 32'd0, $random(seed), 4'b0101, 1'b0);
    write_row("l2 w4 part", L2Base + 32'd16, $random(seed), 4'b1000, 1'b0);
    write_row("l2 w1 part", L2Base + 32'd4, $random(seed), 4'b0110, 1'b0);
    read_row("l2 r0", L2Base + 32'd0, '0, 1'b1, 1'b0);
    read_row("l2 r1", L2Base + 32'd4, '0, 1'b1, 1'b0);
    read_row("l2 r4", L2Base + 32'd16, '0, 1'b1, 1'b0);
    read_row("l2 r255", L2Base + 32'd1020, '0, 1'b1, 1'b0);
    apply_rows();

    write_row("gpio out wr", reg_addr(host_periph_pkg::REG_GPIO_OUT), 32'hFFFF_A5C3, 4'hf, 1'b0);
    read_row("gpio out rd", reg_addr(host_periph_pkg::REG_GPIO_OUT), 32'h0000_A5C3, 1'b0, 1'b0);
    write_row("gpio dir wr", reg_addr(host_periph_pkg::REG_GPIO_DIR), 32'h0000_0FF0, 4'hf, 1'b0);
    read_row("gpio dir rd", reg_addr(host_periph_pkg::REG_GPIO_DIR), 32'h0000_0FF0, 1'b0, 1'b0);
    apply_rows();
    check_val("gpio pads out", 32'h0000_A5C3, 32'(gpio_pads.gpio_out));
    check_val("gpio pads dir", 32'h0000_0FF0, 32'(gpio_pads.gpio_dir));

    // Two synchroniser stages, three cycles leave margin
    gpio_in = 16'h3C96;
    repeat (3) @(negedge clk);
    read_row("gpio in rd", reg_addr(host_periph_pkg::REG_GPIO_IN), 32'h0000_3C96, 1'b0, 1'b0);
    apply_rows();

    write_row("event clear", reg_addr(host_periph_pkg::REG_EVENT_CNT), '0, 4'hf, 1'b0);
    apply_rows();
    event_in = 1'b1;
    repeat (7) @(negedge clk);
    event_in = 1'b0;
    read_row("event count", reg_addr(host_periph_pkg::REG_EVENT_CNT), 32'd7, 1'b0, 1'b0);
    write_row("event clear2", reg_addr(host_periph_pkg::REG_EVENT_CNT), 32'h55, 4'hf, 1'b0);
    read_row("event zero", reg_addr(host_periph_pkg::REG_EVENT_CNT), 32'd0, 1'b0, 1'b0);
    write_row("scratch full", reg_addr(host_periph_pkg::REG_SCRATCH), 32'h1122_3344, 4'hf, 1'b0);
    write_row("scratch byte", reg_addr(host_periph_pkg::REG_SCRATCH), 32'h0000_AA00, 4'b0010,
              1'b0);
    read_row("scratch rd", reg_addr(host_periph_pkg::REG_SCRATCH), 32'h1122_AA44, 1'b0, 1'b0);
    read_row("id rd", reg_addr(host_periph_pkg::REG_ID), `HOST_PERIPH_ID, 1'b0, 1'b0);
    apply_rows();

    // Rejected accesses, followed by reads of what they aimed at
    read_row("unmapped rd", 32'h3000_0000, '0, 1'b0, 1'b1);
    write_row("unmapped wr", PerBase + 32'h40, 32'hDEAD_BEEF, 4'hf, 1'b1);
    write_row("id wr", reg_addr(host_periph_pkg::REG_ID), 32'h0, 4'hf, 1'b1);
    read_row("id kept", reg_addr(host_periph_pkg::REG_ID), `HOST_PERIPH_ID, 1'b0, 1'b0);
    write_row("gpio in wr", reg_addr(host_periph_pkg::REG_GPIO_IN), 32'hFFFF, 4'hf, 1'b1);
    read_row("gpio in kept", reg_addr(host_periph_pkg::REG_GPIO_IN), 32'h3C96, 1'b0, 1'b0);
    read_row("slot 9 rd", reg_addr(4'd9), '0, 1'b0, 1'b1);
    write_row("slot 9 wr", reg_addr(4'd9), 32'h1234_5678, 4'hf, 1'b1);
    write_row("slot 6 wr", reg_addr(4'd6), 32'h1234_5678, 4'hf, 1'b1);
    read_row("scratch kept", reg_addr(host_periph_pkg::REG_SCRATCH), 32'h1122_AA44, 1'b0, 1'b0);
    read_row("gpio out kept", reg_addr(host_periph_pkg::REG_GPIO_OUT), 32'hA5C3, 1'b0, 1'b0);
    apply_rows();

    // Mixed traffic, one request in every cycle
    write_row("mix l2 w8", L2Base + 32'd32, $random(seed), 4'hf, 1'b0);
    read_row("mix scratch", reg_addr(host_periph_pkg::REG_SCRATCH), 32'h1122_AA44, 1'b0, 1'b0);
    read_row("mix miss", 32'h0000_0000, '0, 1'b0, 1'b1);
    read_row("mix l2 r8", L2Base + 32'd32, '0, 1'b1, 1'b0);
    write_row("mix gpio wr", reg_addr(host_periph_pkg::REG_GPIO_OUT), 32'h1234, 4'hf, 1'b0);
    read_row("mix id", reg_addr(host_periph_pkg::REG_ID), `HOST_PERIPH_ID, 1'b0, 1'b0);
    read_row("mix l2 r0", L2Base + 32'd0, '0, 1'b1, 1'b0);
    read_row("mix gpio rd", reg_addr(host_periph_pkg::REG_GPIO_OUT), 32'h1234, 1'b0, 1'b0);
    apply_rows();
    @(negedge clk);
    check_val("idle rsp valid", 32'd0, 32'(rsp.valid));

    $display("Errors: %0d, timeouts: %0d", err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
